// ==== design/decodePkg.sv ====
// shared ISA constants for the 16-bit decode stage; opcodes not listed here decode as NOP
`default_nettype none

package decodePkg;

	// machine word and PC width, fixed by the ISA
	localparam int dataWidth = 16;

	// 5-bit opcodes in instr[15:11]
	localparam logic [4:0] opHalt  = 5'b00000;
	localparam logic [4:0] opNop   = 5'b00001;
	localparam logic [4:0] opAddi  = 5'b01000;
	localparam logic [4:0] opSt    = 5'b10000;
	localparam logic [4:0] opLd    = 5'b10001;
	localparam logic [4:0] opRtype = 5'b11011;
	localparam logic [4:0] opBeqz  = 5'b01100;
	localparam logic [4:0] opBnez  = 5'b01101;
	localparam logic [4:0] opJ     = 5'b00100;
	localparam logic [4:0] opJr    = 5'b00101;
	localparam logic [4:0] opJal   = 5'b00110;

	// bubble word, opcode field is opNop
	localparam logic [dataWidth-1:0] nopInstr = 16'h0800;

	// JAL link register
	localparam logic [2:0] linkReg = 3'd7;

	// immediate field selection
	typedef enum logic [1:0] {
		// I-format 1, bits 4..0
		fmtImm5,
		// I-format 2, bits 7..0
		fmtImm8,
		// J-format, bits 10..0
		fmtDisp11,
		// no immediate, reads as zero
		fmtNone
	} immFormat;

	// ALU operation handed to execute
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluPass
	} aluOp;

endpackage

`default_nettype wire

// ==== design/controlUnit.sv ====
// purely combinational; stall forces NOP strobes, but immKind always follows the raw instruction
`default_nettype none

module controlUnit (
	input  logic [decodePkg::dataWidth-1:0] instr,
	input  logic                            stall,
	output logic                            isNotHalt,
	output logic                            isNop,
	output logic                            isJal,
	output logic                            isJr,
	output logic                            isJump,
	output logic                            isBranch,
	output logic                            isMemToReg,
	output logic                            isMemRead,
	output logic                            isMemWrite,
	output logic                            aluSrc,
	output logic                            isRegWrite,
	output decodePkg::aluOp                 aluOp,
	output decodePkg::immFormat             immKind
);

	logic [decodePkg::dataWidth-1:0] ctrlInstr;
	logic [4:0]                      opcode;
	logic [4:0]                      rawOpcode;

	// stalled slot becomes a bubble before decode
	assign ctrlInstr = stall ? decodePkg::nopInstr : instr;
	assign opcode = ctrlInstr[15:11];
	assign rawOpcode = instr[15:11];

	always_comb begin
		// defaults are the NOP values except isNop itself
		isNotHalt = 1'b1;
		isNop = 1'b0;
		isJal = 1'b0;
		isJr = 1'b0;
		isJump = 1'b0;
		isBranch = 1'b0;
		isMemToReg = 1'b0;
		isMemRead = 1'b0;
		isMemWrite = 1'b0;
		aluSrc = 1'b0;
		isRegWrite = 1'b0;
		aluOp = decodePkg::aluPass;
		case (opcode)
			decodePkg::opHalt: isNotHalt = 1'b0;
			decodePkg::opNop: isNop = 1'b1;
			decodePkg::opAddi: begin
				aluSrc = 1'b1;
				isRegWrite = 1'b1;
				aluOp = decodePkg::aluAdd;
			end
			decodePkg::opLd: begin
				aluSrc = 1'b1;
				isRegWrite = 1'b1;
				isMemRead = 1'b1;
				isMemToReg = 1'b1;
				aluOp = decodePkg::aluAdd;
			end
			decodePkg::opSt: begin
				aluSrc = 1'b1;
				isMemWrite = 1'b1;
				aluOp = decodePkg::aluAdd;
			end
			decodePkg::opRtype: begin
				isRegWrite = 1'b1;
				// function field picks the ALU op
				case (ctrlInstr[1:0])
					2'b00: aluOp = decodePkg::aluAdd;
					2'b01: aluOp = decodePkg::aluSub;
					2'b10: aluOp = decodePkg::aluAnd;
					default: aluOp = decodePkg::aluOr;
				endcase
			end
			decodePkg::opBeqz, decodePkg::opBnez: isBranch = 1'b1;
			decodePkg::opJ: isJump = 1'b1;
			decodePkg::opJr: begin
				isJump = 1'b1;
				isJr = 1'b1;
			end
			decodePkg::opJal: begin
				isJump = 1'b1;
				isJal = 1'b1;
				isRegWrite = 1'b1;
			end
			// unknown opcode acts as a bubble
			default: isNop = 1'b1;
		endcase
	end

	// immediate format from the raw word so fields stay valid under stall
	always_comb begin
		case (rawOpcode)
			decodePkg::opAddi, decodePkg::opLd, decodePkg::opSt: immKind = decodePkg::fmtImm5;
			decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opJr: immKind = decodePkg::fmtImm8;
			decodePkg::opJ, decodePkg::opJal: immKind = decodePkg::fmtDisp11;
			default: immKind = decodePkg::fmtNone;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/instrFields.sv ====
// field extraction from the raw instruction; selects are 3 bits, so it serves an 8-entry file only
`default_nettype none

module instrFields (
	input  logic [decodePkg::dataWidth-1:0] instr,
	input  decodePkg::immFormat             immKind,
	input  logic                            isJal,
	output logic [2:0]                      readReg1,
	output logic [2:0]                      readReg2,
	output logic [2:0]                      writeRegSel,
	output logic [decodePkg::dataWidth-1:0] immed
);

	localparam int w = decodePkg::dataWidth;

	logic [4:0] opcode;

	assign opcode = instr[15:11];

	// source selects sit at fixed positions in every format
	assign readReg1 = instr[10:8];
	assign readReg2 = instr[7:5];

	// sign extension per format
	always_comb begin
		case (immKind)
			decodePkg::fmtImm5: immed = {{(w - 5){instr[4]}}, instr[4:0]};
			decodePkg::fmtImm8: immed = {{(w - 8){instr[7]}}, instr[7:0]};
			decodePkg::fmtDisp11: immed = {{(w - 11){instr[10]}}, instr[10:0]};
			default: immed = '0;
		endcase
	end

	// destination select
	always_comb begin
		writeRegSel = '0;
		if (isJal) begin
			// link address goes to r7
			writeRegSel = decodePkg::linkReg;
		end else if (immKind == decodePkg::fmtNone) begin
			// R-type rd in bits 4..2; halt and nop share this format but write nothing
			if (opcode == decodePkg::opRtype) begin
				writeRegSel = instr[4:2];
			end
		end else if (immKind == decodePkg::fmtImm5) begin
			// ADDI and LD target bits 7..5, store has no destination
			if (opcode != decodePkg::opSt) begin
				writeRegSel = instr[7:5];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/regWriteDecode.sv ====
// one-hot write enables; writeReg must stay below numRegs, clk and rst only feed the check
`default_nettype none

module regWriteDecode #(
	parameter int numRegs = 8,
	localparam int selWidth = $clog2(numRegs)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                writeEn,
	input  logic [selWidth-1:0] writeReg,
	output logic [numRegs-1:0]  wordEn
);

	// shift a single one into place, nothing without the strobe
	always_comb begin
		wordEn = '0;
		if (writeEn) begin
			wordEn[writeReg] = 1'b1;
		end
	end

	// exactly one word per strobe and none without it, strobe always a known level
	wordEnLegal: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(writeEn) && (writeEn ? $onehot(wordEn) : (wordEn == '0))
	) else $error("regWriteDecode: bad write enable %b", wordEn);

endmodule

`default_nettype wire

// ==== design/regWord.sv ====
// one register word; holds its value unless en is high, cleared by synchronous reset
`default_nettype none

module regWord (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            en,
	input  logic [decodePkg::dataWidth-1:0] d,
	output logic [decodePkg::dataWidth-1:0] q
);

	// registers read zero after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== design/regReadMux.sv ====
// two combinational read ports; a same-cycle write wins over the stored word
`default_nettype none

module regReadMux #(
	parameter int numRegs = 8,
	localparam int selWidth = $clog2(numRegs)
) (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic [numRegs*decodePkg::dataWidth-1:0] words,
	input  logic [selWidth-1:0]                     readReg1,
	input  logic [selWidth-1:0]                     readReg2,
	input  logic                                    writeEn,
	input  logic [selWidth-1:0]                     writeReg,
	input  logic [decodePkg::dataWidth-1:0]         writeData,
	output logic [decodePkg::dataWidth-1:0]         rdData1,
	output logic [decodePkg::dataWidth-1:0]         rdData2
);

	localparam int w = decodePkg::dataWidth;

	logic [w-1:0] stored1;
	logic [w-1:0] stored2;
	logic         hit1;
	logic         hit2;

	// word select out of the flat bus
	assign stored1 = words[readReg1*w +: w];
	assign stored2 = words[readReg2*w +: w];

	// bypass when write-back targets the same register
	assign hit1 = writeEn && (writeReg == readReg1);
	assign hit2 = writeEn && (writeReg == readReg2);

	assign rdData1 = hit1 ? writeData : stored1;
	assign rdData2 = hit2 ? writeData : stored2;

	// read selects come straight from the instruction word
	readSelKnown: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown({readReg1, readReg2})
	) else $error("regReadMux: unknown read select");

endmodule

`default_nettype wire

// ==== design/branchResolve.sv ====
// branch and jump resolution in decode; one adder shared by all targets, no prediction
`default_nettype none

module branchResolve (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            isBranch,
	input  logic                            isJump,
	input  logic                            isJr,
	input  logic                            isNotHalt,
	input  logic                            opBit0,
	input  logic [decodePkg::dataWidth-1:0] rdData1,
	input  logic [decodePkg::dataWidth-1:0] immed,
	input  logic [decodePkg::dataWidth-1:0] newAddr,
	input  logic [decodePkg::dataWidth-1:0] currPc,
	output logic [decodePkg::dataWidth-1:0] pcNext,
	output logic                            flush
);

	logic [decodePkg::dataWidth-1:0] base;
	logic [decodePkg::dataWidth-1:0] target;
	logic [decodePkg::dataWidth-1:0] resolved;
	logic                            rsZero;
	logic                            taken;
	logic                            redirect;

	// JR is register relative, everything else PC relative
	assign base = isJr ? rdData1 : newAddr;
	assign target = base + immed;

	// BEQZ has opBit0 low, BNEZ high
	assign rsZero = (rdData1 == '0);
	assign taken = isBranch && (opBit0 ? !rsZero : rsZero);

	assign redirect = isBranch || isJump;

	// untaken branch falls through
	assign resolved = (isJump || taken) ? target : newAddr;

	// halt holds the PC
	always_comb begin
		if (!isNotHalt) begin
			pcNext = currPc;
		end else if (redirect) begin
			pcNext = resolved;
		end else begin
			pcNext = newAddr;
		end
	end

	// a zero-offset taken branch lands on newAddr and needs no flush
	assign flush = redirect && (resolved != newAddr);

	// flush only from one control transfer, never from a branch and a jump at once
	flushNeedsRedirect: assert property (
		@(posedge clk) disable iff (rst)
		flush |-> (isBranch != isJump)
	) else $error("branchResolve: flush without a single branch or jump");

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
// decode stage top; all outputs are combinational, register writes land on the next clk edge
`default_nettype none

module decodeStage #(
	parameter int numRegs = 8,
	localparam int selWidth = $clog2(numRegs)
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [decodePkg::dataWidth-1:0] instr,
	input  logic [decodePkg::dataWidth-1:0] currPc,
	input  logic [decodePkg::dataWidth-1:0] newAddr,
	input  logic                            stall,
	input  logic                            writeEn,
	input  logic [selWidth-1:0]             writeReg,
	input  logic [decodePkg::dataWidth-1:0] writeData,
	output logic                            isNotHalt,
	output logic                            isNop,
	output logic                            isJal,
	output logic                            isJr,
	output logic                            isJump,
	output logic                            isBranch,
	output logic                            isMemToReg,
	output logic                            isMemRead,
	output logic                            isMemWrite,
	output logic                            aluSrc,
	output logic                            isRegWrite,
	output decodePkg::aluOp                 aluOp,
	output logic [decodePkg::dataWidth-1:0] immed,
	output logic [decodePkg::dataWidth-1:0] rdData1,
	output logic [decodePkg::dataWidth-1:0] rdData2,
	output logic [selWidth-1:0]             writeRegSel,
	output logic [selWidth-1:0]             readReg1,
	output logic [selWidth-1:0]             readReg2,
	output logic [decodePkg::dataWidth-1:0] pcNext,
	output logic                            flush
);

	localparam int w = decodePkg::dataWidth;

	decodePkg::immFormat      immKind;
	logic [numRegs-1:0]       wordEn;
	logic [numRegs*w-1:0]     words;

	// instruction fields carry 3-bit register selects
	if (selWidth != 3) begin : gSelCheck
		$error("decodeStage: numRegs must be 8 for 3-bit register fields");
	end

	controlUnit controlUnit_i (
		.instr(instr),
		.stall(stall),
		.isNotHalt(isNotHalt),
		.isNop(isNop),
		.isJal(isJal),
		.isJr(isJr),
		.isJump(isJump),
		.isBranch(isBranch),
		.isMemToReg(isMemToReg),
		.isMemRead(isMemRead),
		.isMemWrite(isMemWrite),
		.aluSrc(aluSrc),
		.isRegWrite(isRegWrite),
		.aluOp(aluOp),
		.immKind(immKind)
	);

	// fields from the raw word, not the stalled one
	instrFields instrFields_i (
		.instr(instr),
		.immKind(immKind),
		.isJal(isJal),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeRegSel(writeRegSel),
		.immed(immed)
	);

	regWriteDecode #(.numRegs(numRegs)) regWriteDecode_i (
		.clk(clk),
		.rst(rst),
		.writeEn(writeEn),
		.writeReg(writeReg),
		.wordEn(wordEn)
	);

	// register file words on one flat bus
	for (genvar i = 0; i < numRegs; i++) begin : gWord
		regWord regWord_i (
			.clk(clk),
			.rst(rst),
			.en(wordEn[i]),
			.d(writeData),
			.q(words[i*w +: w])
		);
	end

	regReadMux #(.numRegs(numRegs)) regReadMux_i (
		.clk(clk),
		.rst(rst),
		.words(words),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeEn(writeEn),
		.writeReg(writeReg),
		.writeData(writeData),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	// opcode bit 0 tells BNEZ from BEQZ
	branchResolve branchResolve_i (
		.clk(clk),
		.rst(rst),
		.isBranch(isBranch),
		.isJump(isJump),
		.isJr(isJr),
		.isNotHalt(isNotHalt),
		.opBit0(instr[11]),
		.rdData1(rdData1),
		.immed(immed),
		.newAddr(newAddr),
		.currPc(currPc),
		.pcNext(pcNext),
		.flush(flush)
	);

endmodule

`default_nettype wire

// ==== tests/decodeStageTb.sv ====
// table-driven decode stage check; r0 is preloaded with zero so BEQZ and BNEZ see both cases
`default_nettype none

module decodeStageTb;
	timeunit 1ns;
	timeprecision 1ps;

	// ctrl is {isNotHalt, isNop, isJal, isJr, isJump, isBranch, isMemToReg, isMemRead,
	// isMemWrite, aluSrc, isRegWrite}, flags is {flush, fromRegs}
	typedef struct packed {
		logic        stall;
		logic [15:0] instr;
		logic [15:0] currPc;
		logic [15:0] newAddr;
		logic [10:0] ctrl;
		logic [3:0]  aluOp;
		logic [2:0]  wrSel;
		logic [15:0] immed;
		logic [15:0] pcNext;
		logic [1:0]  flags;
	} stepRow;

	localparam logic [3:0] addOp = decodePkg::aluAdd;
	localparam logic [3:0] subOp = decodePkg::aluSub;
	localparam logic [3:0] andOp = decodePkg::aluAnd;
	localparam logic [3:0] orOp = decodePkg::aluOr;
	localparam logic [3:0] passOp = decodePkg::aluPass;
	localparam int numRows = 27;

	// fromRegs rows get pcNext and flush from the register model
	localparam stepRow rows [numRows] = '{
		'{1'b0, 16'h0000, 16'h1234, 16'h1236, 11'h000, passOp, 3'd0, 16'h0000, 16'h1234, 2'b00},
		'{1'b0, 16'h0800, 16'h0100, 16'h0102, 11'h600, passOp, 3'd0, 16'h0000, 16'h0102, 2'b00},
		'{1'b0, 16'h415D, 16'h0100, 16'h0102, 11'h403, addOp, 3'd2, 16'hFFFD, 16'h0102, 2'b00},
		'{1'b0, 16'h43A7, 16'h0100, 16'h0102, 11'h403, addOp, 3'd5, 16'h0007, 16'h0102, 2'b00},
		'{1'b0, 16'h8E8F, 16'h0100, 16'h0102, 11'h41B, addOp, 3'd4, 16'h000F, 16'h0102, 2'b00},
		'{1'b0, 16'h82B0, 16'h0100, 16'h0102, 11'h406, addOp, 3'd0, 16'hFFF0, 16'h0102, 2'b00},
		'{1'b0, 16'hD94C, 16'h0100, 16'h0102, 11'h401, addOp, 3'd3, 16'h0000, 16'h0102, 2'b00},
		'{1'b0, 16'hD94D, 16'h0100, 16'h0102, 11'h401, subOp, 3'd3, 16'h0000, 16'h0102, 2'b00},
		'{1'b0, 16'hDFDA, 16'h0100, 16'h0102, 11'h401, andOp, 3'd6, 16'h0000, 16'h0102, 2'b00},
		'{1'b0, 16'hDC07, 16'h0100, 16'h0102, 11'h401, orOp, 3'd1, 16'h0000, 16'h0102, 2'b00},
		'{1'b0, 16'hFFFF, 16'h0100, 16'h0102, 11'h600, passOp, 3'd0, 16'h0000, 16'h0102, 2'b00},
		'{1'b0, 16'h9000, 16'h0100, 16'h0102, 11'h600, passOp, 3'd0, 16'h0000, 16'h0102, 2'b00},
		'{1'b0, 16'h6008, 16'h0100, 16'h0102, 11'h420, passOp, 3'd0, 16'h0008, 16'h0000, 2'b01},
		'{1'b0, 16'h63FA, 16'h0100, 16'h0102, 11'h420, passOp, 3'd0, 16'hFFFA, 16'h0000, 2'b01},
		'{1'b0, 16'h60FA, 16'h0100, 16'h0102, 11'h420, passOp, 3'd0, 16'hFFFA, 16'h0000, 2'b01},
		'{1'b0, 16'h6BFC, 16'h0100, 16'h0102, 11'h420, passOp, 3'd0, 16'hFFFC, 16'h0000, 2'b01},
		'{1'b0, 16'h6820, 16'h0100, 16'h0102, 11'h420, passOp, 3'd0, 16'h0020, 16'h0000, 2'b01},
		'{1'b0, 16'h6000, 16'h0100, 16'h0102, 11'h420, passOp, 3'd0, 16'h0000, 16'h0000, 2'b01},
		'{1'b0, 16'h2100, 16'h0100, 16'h0102, 11'h440, passOp, 3'd0, 16'h0100, 16'h0202, 2'b10},
		'{1'b0, 16'h27F0, 16'h0100, 16'h0102, 11'h440, passOp, 3'd0, 16'hFFF0, 16'h00F2, 2'b10},
		'{1'b0, 16'h37FE, 16'h0100, 16'h0102, 11'h541, passOp, 3'd7, 16'hFFFE, 16'h0100, 2'b10},
		'{1'b0, 16'h33FF, 16'h0100, 16'h0102, 11'h541, passOp, 3'd7, 16'h03FF, 16'h0501, 2'b10},
		'{1'b0, 16'h2D04, 16'h0100, 16'h0102, 11'h4C0, passOp, 3'd0, 16'h0004, 16'h0000, 2'b01},
		'{1'b0, 16'h2EFE, 16'h0100, 16'h0102, 11'h4C0, passOp, 3'd0, 16'hFFFE, 16'h0000, 2'b01},
		'{1'b1, 16'h6008, 16'h0100, 16'h0102, 11'h600, passOp, 3'd0, 16'h0008, 16'h0102, 2'b00},
		'{1'b1, 16'h82B0, 16'h0100, 16'h0102, 11'h600, passOp, 3'd0, 16'hFFF0, 16'h0102, 2'b00},
		'{1'b1, 16'h415D, 16'h0100, 16'h0102, 11'h600, passOp, 3'd2, 16'hFFFD, 16'h0102, 2'b00}
	};

	logic clk;
	logic rst;
	logic stall;
	logic writeEn;
	logic [2:0] writeReg;
	logic [15:0] instr;
	logic [15:0] currPc;
	logic [15:0] newAddr;
	logic [15:0] writeData;
	logic isNotHalt;
	logic isNop;
	logic isJal;
	logic isJr;
	logic isJump;
	logic isBranch;
	logic isMemToReg;
	logic isMemRead;
	logic isMemWrite;
	logic aluSrc;
	logic isRegWrite;
	decodePkg::aluOp aluOp;
	logic [15:0] immed;
	logic [15:0] rdData1;
	logic [15:0] rdData2;
	logic [2:0] writeRegSel;
	logic [2:0] readReg1;
	logic [2:0] readReg2;
	logic [15:0] pcNext;
	logic flush;

	// software copy of the register file
	logic [15:0] regModel [8];
	logic [31:0] lcgState;
	int valueErrors;
	int timeoutErrors;

	decodeStage #(.numRegs(8)) decodeStage_i (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// NOP word that still carries two read selects
	function automatic logic [15:0] readInstr(input logic [2:0] r1, input logic [2:0] r2);
		return {decodePkg::opNop, r1, r2, 5'b00000};
	endfunction

	task automatic reportMismatch(input string name, input logic [15:0] expVal,
			input logic [15:0] actVal);
		valueErrors++;
		$display("Error at %0d ns: %s expected 0x%h, got 0x%h", $time, name, expVal, actVal);
	endtask

	initial begin
		int cycles;
		stepRow row;
		logic [15:0] value;
		logic [15:0] exp1;
		logic [15:0] exp2;
		logic [15:0] expPc;
		logic [15:0] rsVal;
		logic expFlush;
		clk = 1'b0;
		rst = 1'b1;
		stall = 1'b0;
		writeEn = 1'b0;
		writeReg = 3'd0;
		writeData = 16'h0000;
		instr = decodePkg::nopInstr;
		currPc = 16'h0000;
		newAddr = 16'h0002;
		valueErrors = 0;
		timeoutErrors = 0;
		lcgState = 32'd88794;
		for (int r = 0; r < 8; r++) begin
			regModel[r] = 16'h0000;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		// read port must leave X once the words are cleared
		cycles = 0;
		@(negedge clk);
		while ($isunknown(rdData1) && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles == 8) begin
			timeoutErrors++;
			$display("Timeout: register file still reads unknown after reset");
		end
		// every word reads zero after reset
		for (int r = 0; r < 8; r++) begin
			@(posedge clk);
			instr <= readInstr(r[2:0], 3'(7 - r));
			@(negedge clk);
			if (rdData1 !== 16'h0000) reportMismatch("rdData1", 16'h0000, rdData1);
			if (rdData2 !== 16'h0000) reportMismatch("rdData2", 16'h0000, rdData2);
		end
		// preload, r0 stays zero and the rest are nonzero
		for (int r = 0; r < 8; r++) begin
			lcgState = lcgStep(lcgState);
			value = (r == 0) ? 16'h0000 : lcgState[30:15];
			if (r != 0 && value == 16'h0000) value = 16'h8001;
			@(posedge clk);
			writeEn <= 1'b1;
			writeReg <= r[2:0];
			writeData <= value;
			// bypass alternates between the two read ports
			if (r % 2 == 0) begin
				instr <= readInstr(r[2:0], 3'(r + 1));
			end else begin
				instr <= readInstr(3'(r + 1), r[2:0]);
			end
			exp1 = (r % 2 == 0) ? value : regModel[(r + 1) % 8];
			exp2 = (r % 2 == 0) ? regModel[(r + 1) % 8] : value;
			@(negedge clk);
			// bypass on one port, untouched word on the other
			if (rdData1 !== exp1) reportMismatch("rdData1", exp1, rdData1);
			if (rdData2 !== exp2) reportMismatch("rdData2", exp2, rdData2);
			@(posedge clk);
			writeEn <= 1'b0;
			@(negedge clk);
			// stored word once the write edge has passed
			if (rdData1 !== exp1) reportMismatch("rdData1", exp1, rdData1);
			if (rdData2 !== exp2) reportMismatch("rdData2", exp2, rdData2);
			regModel[r] = value;
		end
		for (int i = 0; i < numRows; i++) begin
			row = rows[i];
			@(posedge clk);
			stall <= row.stall;
			instr <= row.instr;
			currPc <= row.currPc;
			newAddr <= row.newAddr;
			@(negedge clk);
			expPc = row.pcNext;
			expFlush = row.flags[1];
			if (row.flags[0]) begin
				// branch and JR rules against the model contents
				rsVal = regModel[row.instr[10:8]];
				if (row.instr[15:11] == decodePkg::opJr) begin
					expPc = rsVal + row.immed;
				end else if (row.instr[15:11] == decodePkg::opBeqz) begin
					expPc = (rsVal == 16'h0000) ? row.newAddr + row.immed : row.newAddr;
				end else begin
					expPc = (rsVal != 16'h0000) ? row.newAddr + row.immed : row.newAddr;
				end
				expFlush = (expPc != row.newAddr);
			end
			if (isNotHalt !== row.ctrl[10]) reportMismatch("isNotHalt", row.ctrl[10], isNotHalt);
			if (isNop !== row.ctrl[9]) reportMismatch("isNop", row.ctrl[9], isNop);
			if (isJal !== row.ctrl[8]) reportMismatch("isJal", row.ctrl[8], isJal);
			if (isJr !== row.ctrl[7]) reportMismatch("isJr", row.ctrl[7], isJr);
			if (isJump !== row.ctrl[6]) reportMismatch("isJump", row.ctrl[6], isJump);
			if (isBranch !== row.ctrl[5]) reportMismatch("isBranch", row.ctrl[5], isBranch);
			if (isMemToReg !== row.ctrl[4]) begin
				reportMismatch("isMemToReg", row.ctrl[4], isMemToReg);
			end
			if (isMemRead !== row.ctrl[3]) reportMismatch("isMemRead", row.ctrl[3], isMemRead);
			if (isMemWrite !== row.ctrl[2]) reportMismatch("isMemWrite", row.ctrl[2], isMemWrite);
			if (aluSrc !== row.ctrl[1]) reportMismatch("aluSrc", row.ctrl[1], aluSrc);
			if (isRegWrite !== row.ctrl[0]) reportMismatch("isRegWrite", row.ctrl[0], isRegWrite);
			if (aluOp !== row.aluOp) reportMismatch("aluOp", row.aluOp, aluOp);
			if (writeRegSel !== row.wrSel) reportMismatch("writeRegSel", row.wrSel, writeRegSel);
			if (readReg1 !== row.instr[10:8]) reportMismatch("readReg1", row.instr[10:8], readReg1);
			if (readReg2 !== row.instr[7:5]) reportMismatch("readReg2", row.instr[7:5], readReg2);
			if (immed !== row.immed) reportMismatch("immed", row.immed, immed);
			if (rdData1 !== regModel[row.instr[10:8]]) begin
				reportMismatch("rdData1", regModel[row.instr[10:8]], rdData1);
			end
			if (pcNext !== expPc) reportMismatch("pcNext", expPc, pcNext);
			if (flush !== expFlush) reportMismatch("flush", expFlush, flush);
		end
		$display("Run finished with %0d value errors and %0d timeouts", valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== decodeStage.f ====
design/decodePkg.sv
design/controlUnit.sv
design/instrFields.sv
design/regWriteDecode.sv
design/regWord.sv
design/regReadMux.sv
design/branchResolve.sv
design/decodeStage.sv
tests/decodeStageTb.sv

// ==== Bender.yml ====
package:
  name: decodeStage

sources:
  - files:
      - design/decodePkg.sv
      - design/controlUnit.sv
      - design/instrFields.sv
      - design/regWriteDecode.sv
      - design/regWord.sv
      - design/regReadMux.sv
      - design/branchResolve.sv
      - design/decodeStage.sv
  - target: test
    files:
      - tests/decodeStageTb.sv
